/* design/qsim_macros.svh */
`ifndef QSIM_MACROS_SVH
`define QSIM_MACROS_SVH

// ------------------------------
// problem size limits
// ------------------------------

// largest qubit count accepted in the header
`define QSIM_MAX_QUBITS 4

// ------------------------------
// sram geometry
// ------------------------------

// one sram word, header or complex amplitude
`define QSIM_WORD_W 32
`define QSIM_ADDR_W 16

// ------------------------------
// fixed point format
// ------------------------------

// signed q1.14 per real / imag part
`define QSIM_AMP_W 16
`define QSIM_FRAC_W 14

// read address issue to accumulator holding that element
`define QSIM_PIPE_DEPTH 4

`endif

/* design/qsim_pkg.sv */
`include "qsim_macros.svh"
`default_nettype none

package qsim_pkg;

  // ------------------------------
  // data words
  // ------------------------------

  // complex amplitude, real part in the upper half
  typedef struct packed {
    logic signed [`QSIM_AMP_W-1:0] re;
    logic signed [`QSIM_AMP_W-1:0] im;
  } qsim_amp_t;

  // job header, only found at input address 0
  typedef struct packed {
    logic [`QSIM_WORD_W/2-1:0] num_qubits;
    logic [`QSIM_WORD_W/2-1:0] num_gates;
  } qsim_hdr_t;

  // same sram word, header view or amplitude view
  typedef union packed {
    qsim_hdr_t hdr;
    qsim_amp_t amp;
  } qsim_word_u;

  // ------------------------------
  // sram ports and pipeline tag
  // ------------------------------

  typedef struct packed {
    logic [`QSIM_ADDR_W-1:0] addr;
  } qsim_rd_port_t;

  typedef struct packed {
    logic                    en;
    logic [`QSIM_ADDR_W-1:0] addr;
    qsim_word_u              data;
  } qsim_wr_port_t;

  // rides along with each matrix element
  typedef struct packed {
    logic valid;
    logic first;
    logic last;
  } qsim_tag_t;

endpackage

`default_nettype wire

/* design/qsim_controller.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_controller import qsim_pkg::*; (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        dut_valid,
  output logic                        dut_ready,
  output qsim_rd_port_t               hdr_rd,
  input  qsim_word_u                  hdr_data,
  output logic                        start_pass,
  output logic [`QSIM_MAX_QUBITS:0]   q_dim,
  output logic [`QSIM_MAX_QUBITS-1:0] mask,
  output logic [`QSIM_ADDR_W-1:0]     gate_offset,
  output logic                        src_scratch,
  input  logic                        pass_issued
);

  localparam int QW      = $clog2(`QSIM_MAX_QUBITS + 1);
  localparam int HALF_W  = `QSIM_WORD_W / 2;
  localparam int DRAIN_W = $clog2(`QSIM_PIPE_DEPTH + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR_RD,
    S_HDR_CAP,
    S_PASS,
    S_DRAIN,
    S_NEXT
  } state_t;

  state_t                      state;
  state_t                      state_nxt;
  logic                        dut_ready_q;
  logic                        job_start;
  logic [QW-1:0]               num_qubits;
  logic [HALF_W-1:0]           gates_left;
  logic [DRAIN_W-1:0]          drain_cnt;
  logic [2*`QSIM_MAX_QUBITS:0] q_sq;
  logic [`QSIM_ADDR_W-1:0]     gate_step;

  // header always sits at word 0
  assign hdr_rd.addr = '0;

  assign dut_ready = dut_ready_q;
  assign job_start = (state == S_IDLE) && dut_valid && dut_ready_q;

  // ------------------------------
  // matrix geometry from Q
  // ------------------------------
  assign q_dim = {{`QSIM_MAX_QUBITS{1'b0}}, 1'b1} << num_qubits;
  // low bits of 2^Q minus one, Q=4 wraps to all ones
  assign mask  = q_dim[`QSIM_MAX_QUBITS-1:0] - 1'b1;
  // 4^Q elements per gate
  assign q_sq      = q_dim * q_dim;
  assign gate_step = {{(`QSIM_ADDR_W-2*`QSIM_MAX_QUBITS-1){1'b0}}, q_sq};

  // kick the address generator on entry to a pass
  assign start_pass = ((state == S_HDR_CAP) || (state == S_NEXT)) && (gates_left != '0);

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:    if (job_start) state_nxt = S_HDR_RD;
      // sram returns word 0 this cycle
      S_HDR_RD:  state_nxt = S_HDR_CAP;
      S_HDR_CAP: state_nxt = (gates_left == '0) ? S_IDLE : S_PASS;
      S_PASS:    if (pass_issued) state_nxt = S_DRAIN;
      // last row still in the mac
      S_DRAIN:   if (drain_cnt == '0) state_nxt = S_NEXT;
      S_NEXT:    state_nxt = (gates_left == '0) ? S_IDLE : S_PASS;
      default:   state_nxt = S_IDLE;
    endcase
  end

  // ------------------------------
  // state and job registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state       <= S_IDLE;
      dut_ready_q <= 1'b0;
      num_qubits  <= '0;
      gates_left  <= '0;
      drain_cnt   <= '0;
      gate_offset <= '0;
      src_scratch <= 1'b0;
    end else begin
      state       <= state_nxt;
      // ready tracks idle one cycle behind reset release
      dut_ready_q <= (state_nxt == S_IDLE);
      if (job_start) begin
        gate_offset <= '0;
        src_scratch <= 1'b0;
      end
      // header word valid on the read data now
      if (state == S_HDR_RD) begin
        num_qubits <= hdr_data.hdr.num_qubits[QW-1:0];
        gates_left <= hdr_data.hdr.num_gates;
      end
      if ((state == S_PASS) && pass_issued) begin
        gates_left <= gates_left - 1'b1;
        drain_cnt  <= DRAIN_W'(`QSIM_PIPE_DEPTH);
      end
      if (state == S_DRAIN) begin
        if (drain_cnt == '0) begin
          // pass end, swap ping-pong and move to next gate
          src_scratch <= ~src_scratch;
          gate_offset <= gate_offset + gate_step;
        end else begin
          drain_cnt <= drain_cnt - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/qsim_addr_gen.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_addr_gen import qsim_pkg::*; (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        start_pass,
  input  logic [`QSIM_MAX_QUBITS:0]   q_dim,
  input  logic [`QSIM_MAX_QUBITS-1:0] mask,
  input  logic [`QSIM_ADDR_W-1:0]     gate_offset,
  input  logic                        src_scratch,
  output qsim_rd_port_t               gate_rd,
  output qsim_rd_port_t               state_rd,
  output logic                        state_sel,
  output qsim_tag_t                   tag,
  output logic                        pass_issued
);

  logic [2*`QSIM_MAX_QUBITS-1:0] elem_cnt;
  logic [2*`QSIM_MAX_QUBITS:0]   elem_total;
  logic [`QSIM_MAX_QUBITS-1:0]   col;
  logic                          active;
  logic                          is_last;
  logic                          sel_q;

  // ------------------------------
  // element counter
  // ------------------------------

  // 4^Q elements, row major
  assign elem_total = q_dim * q_dim;
  assign is_last    = ({1'b0, elem_cnt} == (elem_total - 1'b1));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      active   <= 1'b0;
      elem_cnt <= '0;
      sel_q    <= 1'b0;
    end else if (start_pass) begin
      active   <= 1'b1;
      elem_cnt <= '0;
      // source buffer fixed for the whole pass
      sel_q    <= src_scratch;
    end else if (active) begin
      if (is_last) begin
        active <= 1'b0;
      end else begin
        elem_cnt <= elem_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // read addresses
  // ------------------------------

  // column index j within the current row
  assign col = elem_cnt[`QSIM_MAX_QUBITS-1:0] & mask;

  assign gate_rd.addr = gate_offset
                      + {{(`QSIM_ADDR_W-2*`QSIM_MAX_QUBITS){1'b0}}, elem_cnt};

  // input sram keeps the header at 0, so state starts at 1 there
  assign state_rd.addr = {{(`QSIM_ADDR_W-`QSIM_MAX_QUBITS){1'b0}}, col}
                       + {{(`QSIM_ADDR_W-1){1'b0}}, ~sel_q};

  assign state_sel = sel_q;

  // first / last column mark row start and row end
  assign tag = '{
    valid: active,
    first: active & (col == '0),
    last:  active & (col == mask)
  };

  assign pass_issued = active & is_last;

endmodule

`default_nettype wire

/* design/qsim_cmac.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_cmac import qsim_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  qsim_word_u gate_data,
  input  qsim_word_u input_data,
  input  qsim_word_u scratch_data,
  input  qsim_tag_t  tag_in,
  input  logic       state_sel,
  output qsim_amp_t  result,
  output logic       result_last
);

  localparam int AW = `QSIM_AMP_W;

  // tag at each stage
  qsim_tag_t            tag_d;
  qsim_tag_t            tag_s1;
  qsim_tag_t            tag_s2;
  qsim_tag_t            tag_acc;
  logic                 sel_d;
  // gate element and state element
  qsim_amp_t            g_s1;
  qsim_amp_t            s_s1;
  logic signed [AW-1:0] p_rr;
  logic signed [AW-1:0] p_ii;
  logic signed [AW-1:0] p_ri;
  logic signed [AW-1:0] p_ir;
  logic signed [AW-1:0] sum_re;
  logic signed [AW-1:0] sum_im;
  qsim_amp_t            acc;

  // full product, arithmetic shift, keep 16 bits
  function automatic logic signed [AW-1:0] fx_mul(input logic signed [AW-1:0] x,
                                                   input logic signed [AW-1:0] y);
    logic signed [2*AW-1:0] full;
    full = x * y;
    return full[`QSIM_FRAC_W +: AW];
  endfunction

  // ------------------------------
  // tag pipeline
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tag_d   <= '0;
      sel_d   <= 1'b0;
      tag_s1  <= '0;
      tag_s2  <= '0;
      tag_acc <= '0;
    end else begin
      // one cycle of sram latency
      tag_d   <= tag_in;
      sel_d   <= state_sel;
      tag_s1  <= tag_d;
      tag_s2  <= tag_s1;
      tag_acc <= tag_s2;
    end
  end

  // ------------------------------
  // stages 1 and 2
  // ------------------------------
  always_ff @(posedge clk) begin
    // operand select by ping-pong source
    g_s1 <= gate_data.amp;
    s_s1 <= sel_d ? scratch_data.amp : input_data.amp;
    // four partial products
    p_rr <= fx_mul(g_s1.re, s_s1.re);
    p_ii <= fx_mul(g_s1.im, s_s1.im);
    p_ri <= fx_mul(g_s1.re, s_s1.im);
    p_ir <= fx_mul(g_s1.im, s_s1.re);
  end

  // ------------------------------
  // stage 3, accumulate
  // ------------------------------
  assign sum_re = p_rr - p_ii;
  assign sum_im = p_ri + p_ir;

  always_ff @(posedge clk) begin
    if (tag_s2.valid) begin
      // column 0 starts a fresh row sum
      if (tag_s2.first) begin
        acc.re <= sum_re;
        acc.im <= sum_im;
      end else begin
        acc.re <= acc.re + sum_re;
        acc.im <= acc.im + sum_im;
      end
    end
  end

  assign result      = acc;
  assign result_last = tag_acc.valid & tag_acc.last;

endmodule

`default_nettype wire

/* design/qsim_write_back.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_write_back import qsim_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          start_pass,
  input  logic          src_scratch,
  input  qsim_amp_t     result,
  input  logic          result_last,
  output qsim_wr_port_t out_wr,
  output qsim_wr_port_t scratch_wr,
  output qsim_wr_port_t input_wr
);

  logic [`QSIM_ADDR_W-1:0] row_cnt;
  logic [`QSIM_ADDR_W-1:0] wr_row_q;
  qsim_word_u              wr_data_q;
  logic                    src_q;
  logic                    out_en_q;
  logic                    scr_en_q;
  logic                    inp_en_q;

  // ------------------------------
  // row counter and enables
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      row_cnt  <= '0;
      src_q    <= 1'b0;
      out_en_q <= 1'b0;
      scr_en_q <= 1'b0;
      inp_en_q <= 1'b0;
    end else begin
      out_en_q <= result_last;
      // ping-pong target is the buffer not being read
      scr_en_q <= result_last & ~src_q;
      inp_en_q <= result_last & src_q;
      if (start_pass) begin
        row_cnt <= '0;
        src_q   <= src_scratch;
      end else if (result_last) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // row address and amplitude
  always_ff @(posedge clk) begin
    if (result_last) begin
      wr_row_q      <= row_cnt;
      wr_data_q.amp <= result;
    end
  end

  assign out_wr     = '{en: out_en_q, addr: wr_row_q, data: wr_data_q};
  assign scratch_wr = '{en: scr_en_q, addr: wr_row_q, data: wr_data_q};
  // skip the header word
  assign input_wr   = '{en: inp_en_q, addr: wr_row_q + 1'b1, data: wr_data_q};

endmodule

`default_nettype wire

/* design/qsim_top.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_top import qsim_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  // job handshake
  input  logic          dut_valid,
  output logic          dut_ready,
  // input state sram
  output qsim_rd_port_t input_rd,
  output qsim_wr_port_t input_wr,
  input  qsim_word_u    input_rd_data,
  // scratchpad sram
  output qsim_rd_port_t scratch_rd,
  output qsim_wr_port_t scratch_wr,
  input  qsim_word_u    scratch_rd_data,
  // gates sram, read only
  output qsim_rd_port_t gates_rd,
  input  qsim_word_u    gates_rd_data,
  // output state sram, write only
  output qsim_wr_port_t out_wr
);

  qsim_rd_port_t               hdr_rd;
  qsim_rd_port_t               state_rd;
  logic                        start_pass;
  logic [`QSIM_MAX_QUBITS:0]   q_dim;
  logic [`QSIM_MAX_QUBITS-1:0] mask;
  logic [`QSIM_ADDR_W-1:0]     gate_offset;
  logic                        src_scratch;
  logic                        pass_issued;
  logic                        state_sel;
  qsim_tag_t                   tag;
  qsim_amp_t                   result;
  logic                        result_last;

  // ------------------------------
  // read port sharing
  // ------------------------------

  // header address while idle, state stream otherwise
  assign input_rd   = dut_ready ? hdr_rd : state_rd;
  assign scratch_rd = state_rd;

  qsim_controller u_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .dut_valid   (dut_valid),
    .dut_ready   (dut_ready),
    .hdr_rd      (hdr_rd),
    .hdr_data    (input_rd_data),
    .start_pass  (start_pass),
    .q_dim       (q_dim),
    .mask        (mask),
    .gate_offset (gate_offset),
    .src_scratch (src_scratch),
    .pass_issued (pass_issued)
  );

  qsim_addr_gen u_agen (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_pass  (start_pass),
    .q_dim       (q_dim),
    .mask        (mask),
    .gate_offset (gate_offset),
    .src_scratch (src_scratch),
    .gate_rd     (gates_rd),
    .state_rd    (state_rd),
    .state_sel   (state_sel),
    .tag         (tag),
    .pass_issued (pass_issued)
  );

  // ------------------------------
  // datapath
  // ------------------------------
  qsim_cmac u_cmac (
    .clk          (clk),
    .reset_n      (reset_n),
    .gate_data    (gates_rd_data),
    .input_data   (input_rd_data),
    .scratch_data (scratch_rd_data),
    .tag_in       (tag),
    .state_sel    (state_sel),
    .result       (result),
    .result_last  (result_last)
  );

  qsim_write_back u_wb (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_pass  (start_pass),
    .src_scratch (src_scratch),
    .result      (result),
    .result_last (result_last),
    .out_wr      (out_wr),
    .scratch_wr  (scratch_wr),
    .input_wr    (input_wr)
  );

endmodule

`default_nettype wire

/* dv/qsim_tb_mem.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_tb_mem import qsim_pkg::*; #(
  parameter int DEPTH = 1024
) (
  input  logic          clk,
  input  qsim_rd_port_t rd,
  input  qsim_wr_port_t wr,
  output qsim_word_u    rd_data
);

  localparam int IDX_W = $clog2(DEPTH);

  // preloaded and inspected by the testbench
  qsim_word_u mem [DEPTH];

  initial begin
    rd_data = '0;
  end

  // ------------------------------
  // one cycle read, write on en
  // ------------------------------
  always @(posedge clk) begin
    // read returns the old word on a same-address write
    rd_data <= mem[rd.addr[IDX_W-1:0]];
    if (wr.en) begin
      mem[wr.addr[IDX_W-1:0]] <= wr.data;
    end
  end

endmodule

`default_nettype wire

/* dv/qsim_sva.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_sva import qsim_pkg::*; (
  input logic          clk,
  input logic          reset_n,
  input logic          dut_valid,
  input logic          dut_ready,
  input qsim_wr_port_t out_wr,
  input qsim_wr_port_t scratch_wr,
  input qsim_wr_port_t input_wr
);

  // assertion failures so far
  int fail_count = 0;

  // idle engine writes nothing
  assert property (@(posedge clk) disable iff (!reset_n)
    dut_ready |-> !(out_wr.en || scratch_wr.en || input_wr.en))
    else begin
      fail_count++;
      $error("write enable high while dut_ready is high");
    end

  // ping-pong target is one buffer at a time
  assert property (@(posedge clk) disable iff (!reset_n)
    !(scratch_wr.en && input_wr.en))
    else begin
      fail_count++;
      $error("scratch and input writes high together");
    end

  // ready only drops after an accepted job
  assert property (@(posedge clk) disable iff (!reset_n)
    $fell(dut_ready) |-> $past(dut_valid))
    else begin
      fail_count++;
      $error("dut_ready fell without dut_valid");
    end

endmodule

bind qsim_top qsim_sva u_sva (
  .clk        (clk),
  .reset_n    (reset_n),
  .dut_valid  (dut_valid),
  .dut_ready  (dut_ready),
  .out_wr     (out_wr),
  .scratch_wr (scratch_wr),
  .input_wr   (input_wr)
);

`default_nettype wire

/* dv/qsim_tb.sv */
`include "qsim_macros.svh"
`default_nettype none

module qsim_tb import qsim_pkg::*; ();

  localparam int MEM_DEPTH    = 1024;
  localparam int RESET_CYCLES = 16;
  // Q=4 pass, drain, turnaround and pass start
  localparam int PASS_CYCLES  = 256 + `QSIM_PIPE_DEPTH + 3;
  // header read plus two gates
  localparam int JOB_CYCLES   = 4 + 2 * PASS_CYCLES;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 4 * JOB_CYCLES;

  logic          clk;
  logic          reset_n;
  logic          dut_valid;
  logic          dut_ready;
  qsim_rd_port_t input_rd;
  qsim_rd_port_t scratch_rd;
  qsim_rd_port_t gates_rd;
  qsim_rd_port_t no_read;
  qsim_wr_port_t input_wr;
  qsim_wr_port_t scratch_wr;
  qsim_wr_port_t out_wr;
  qsim_wr_port_t no_write;
  qsim_word_u    input_rd_data;
  qsim_word_u    scratch_rd_data;
  qsim_word_u    gates_rd_data;

  // software model of the state vector and gates
  qsim_amp_t     model_state [16];
  qsim_amp_t     saved_state [16];
  qsim_amp_t     model_gates [512];
  logic [31:0]   rng_state;
  int            cycle_count;
  int            error_count;
  int            check_count;
  int            tests_run;
  int            tests_failed;

  assign no_read  = '0;
  assign no_write = '0;

  qsim_top UUT (
    .clk             (clk),
    .reset_n         (reset_n),
    .dut_valid       (dut_valid),
    .dut_ready       (dut_ready),
    .input_rd        (input_rd),
    .input_wr        (input_wr),
    .input_rd_data   (input_rd_data),
    .scratch_rd      (scratch_rd),
    .scratch_wr      (scratch_wr),
    .scratch_rd_data (scratch_rd_data),
    .gates_rd        (gates_rd),
    .gates_rd_data   (gates_rd_data),
    .out_wr          (out_wr)
  );

  qsim_tb_mem #(.DEPTH(MEM_DEPTH)) u_input_mem (
    .clk (clk), .rd (input_rd), .wr (input_wr), .rd_data (input_rd_data)
  );
  qsim_tb_mem #(.DEPTH(MEM_DEPTH)) u_scratch_mem (
    .clk (clk), .rd (scratch_rd), .wr (scratch_wr), .rd_data (scratch_rd_data)
  );
  // gates read only, output write only
  qsim_tb_mem #(.DEPTH(MEM_DEPTH)) u_gates_mem (
    .clk (clk), .rd (gates_rd), .wr (no_write), .rd_data (gates_rd_data)
  );
  qsim_tb_mem #(.DEPTH(MEM_DEPTH)) u_out_mem (
    .clk (clk), .rd (no_read), .wr (out_wr), .rd_data ()
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog on total run length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------
  // random data and model
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // background word, distinct per memory and per address
  function automatic logic [31:0] fill_word(input int sel, input int addr);
    return {16'(addr) ^ 16'hc3a5, 16'(addr * 5 + sel * 4097)};
  endfunction

  // q1.14 product, arithmetic shift, low 16 bits kept
  function automatic logic signed [15:0] scaled_product(input logic signed [15:0] a,
                                                        input logic signed [15:0] b);
    logic signed [31:0] full;
    full = a * b;
    full = full >>> `QSIM_FRAC_W;
    return full[15:0];
  endfunction

  // state = G[g] * state, 16 bit wrapping sums
  task automatic apply_gate(input int q, input int g);
    qsim_amp_t          next_state [16];
    qsim_amp_t          elem;
    qsim_amp_t          amp;
    logic signed [15:0] sum_re;
    logic signed [15:0] sum_im;
    int                 n;
    n = 1 << q;
    for (int i = 0; i < n; i++) begin
      sum_re = '0;
      sum_im = '0;
      for (int j = 0; j < n; j++) begin
        elem   = model_gates[g * n * n + i * n + j];
        amp    = model_state[j];
        sum_re = sum_re + scaled_product(elem.re, amp.re) - scaled_product(elem.im, amp.im);
        sum_im = sum_im + scaled_product(elem.re, amp.im) + scaled_product(elem.im, amp.re);
      end
      next_state[i].re = sum_re;
      next_state[i].im = sum_im;
    end
    for (int i = 0; i < n; i++) begin
      model_state[i] = next_state[i];
    end
  endtask

  task automatic save_state();
    for (int i = 0; i < 16; i++) begin
      saved_state[i] = model_state[i];
    end
  endtask

  // ------------------------------
  // memory setup and job control
  // ------------------------------
  task automatic fill_memories();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      u_input_mem.mem[a]   = fill_word(0, a);
      u_scratch_mem.mem[a] = fill_word(1, a);
      u_gates_mem.mem[a]   = fill_word(2, a);
      u_out_mem.mem[a]     = fill_word(3, a);
    end
  endtask

  // header, random state and M random gates
  task automatic load_job(input int q, input int m);
    qsim_word_u w;
    int         n;
    n = 1 << q;
    w.hdr.num_qubits = 16'(q);
    w.hdr.num_gates  = 16'(m);
    u_input_mem.mem[0] = w;
    for (int j = 0; j < n; j++) begin
      w = next_random();
      model_state[j]         = w.amp;
      u_input_mem.mem[j + 1] = w;
    end
    for (int k = 0; k < m * n * n; k++) begin
      w = next_random();
      model_gates[k]     = w.amp;
      u_gates_mem.mem[k] = w;
    end
  endtask

  // leaves dut_valid high, job accepted on the second edge
  task automatic start_job();
    @(posedge clk);
    dut_valid <= 1'b1;
    @(posedge clk);
  endtask

  task automatic wait_job_done();
    @(negedge clk);
    if (dut_ready) begin
      error_count++;
      $display("job not accepted at %0t, dut_ready stayed high", $time);
    end
    while (!dut_ready) begin
      @(negedge clk);
    end
  endtask

  task automatic run_job();
    start_job();
    dut_valid <= 1'b0;
    wait_job_done();
  endtask

  // ------------------------------
  // checking and reporting
  // ------------------------------
  task automatic check_word(input string where, input int idx,
                            input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s[%0d] is %h, expected %h", $time, where, idx, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, error_count - errors_before);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_and_empty_job();
    int          errors_before;
    logic [31:0] hdr;
    errors_before = error_count;
    @(negedge clk);
    check_flag("dut_ready in first cycle", dut_ready, 1'b0);
    check_flag("write enable after reset", out_wr.en | scratch_wr.en | input_wr.en, 1'b0);
    @(negedge clk);
    check_flag("dut_ready in second cycle", dut_ready, 1'b1);
    // Q=3, no gates
    hdr = {16'd3, 16'd0};
    u_input_mem.mem[0] = hdr;
    run_job();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      check_word("input", a, u_input_mem.mem[a], (a == 0) ? hdr : fill_word(0, a));
      check_word("scratch", a, u_scratch_mem.mem[a], fill_word(1, a));
      check_word("gates", a, u_gates_mem.mem[a], fill_word(2, a));
      check_word("output", a, u_out_mem.mem[a], fill_word(3, a));
    end
    report_test("reset_and_empty_job", errors_before);
  endtask

  task automatic test_single_gate();
    int errors_before;
    errors_before = error_count;
    load_job(2, 1);
    apply_gate(2, 0);
    run_job();
    for (int r = 0; r < 4; r++) begin
      check_word("output", r, u_out_mem.mem[r], model_state[r]);
      check_word("scratch", r, u_scratch_mem.mem[r], model_state[r]);
    end
    report_test("single_gate", errors_before);
  endtask

  task automatic test_ping_pong();
    int errors_before;
    errors_before = error_count;
    load_job(1, 3);
    apply_gate(1, 0);
    apply_gate(1, 1);
    // second pass lands in the input sram
    save_state();
    apply_gate(1, 2);
    run_job();
    for (int r = 0; r < 2; r++) begin
      check_word("output", r, u_out_mem.mem[r], model_state[r]);
      check_word("scratch", r, u_scratch_mem.mem[r], model_state[r]);
      check_word("input", r + 1, u_input_mem.mem[r + 1], saved_state[r]);
    end
    report_test("ping_pong", errors_before);
  endtask

  task automatic test_wide_state();
    int errors_before;
    errors_before = error_count;
    load_job(4, 2);
    apply_gate(4, 0);
    save_state();
    apply_gate(4, 1);
    run_job();
    for (int r = 0; r < 16; r++) begin
      check_word("output", r, u_out_mem.mem[r], model_state[r]);
      check_word("input", r + 1, u_input_mem.mem[r + 1], model_state[r]);
      check_word("scratch", r, u_scratch_mem.mem[r], saved_state[r]);
    end
    report_test("wide_state", errors_before);
  endtask

  task automatic test_back_to_back();
    int errors_before;
    errors_before = error_count;
    load_job(2, 2);
    apply_gate(2, 0);
    apply_gate(2, 1);
    save_state();
    // second job starts from the first job's result
    apply_gate(2, 0);
    apply_gate(2, 1);
    start_job();
    wait_job_done();
    for (int r = 0; r < 4; r++) begin
      check_word("job1 output", r, u_out_mem.mem[r], saved_state[r]);
      check_word("job1 input", r + 1, u_input_mem.mem[r + 1], saved_state[r]);
    end
    // valid still high, second job taken on this edge
    @(posedge clk);
    dut_valid <= 1'b0;
    wait_job_done();
    for (int r = 0; r < 4; r++) begin
      check_word("job2 output", r, u_out_mem.mem[r], model_state[r]);
      check_word("job2 input", r + 1, u_input_mem.mem[r + 1], model_state[r]);
    end
    report_test("back_to_back", errors_before);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rng_state    = 32'hf70a;
    cycle_count  = 0;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_n      = 1'b0;
    dut_valid    = 1'b0;
    fill_memories();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    test_reset_and_empty_job();
    test_single_gate();
    test_ping_pong();
    test_wide_state();
    test_back_to_back();
    // bound checker failures count as errors
    if (UUT.u_sva.fail_count != 0) begin
      $display("bound assertions failed %0d times", UUT.u_sva.fail_count);
      error_count += UUT.u_sva.fail_count;
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/qsim_pkg.sv
design/qsim_controller.sv
design/qsim_addr_gen.sv
design/qsim_cmac.sv
design/qsim_write_back.sv
design/qsim_top.sv
dv/qsim_tb_mem.sv
dv/qsim_sva.sv
dv/qsim_tb.sv
